//--- src/vm_params.svh
`ifndef VM_PARAMS_SVH
`define VM_PARAMS_SVH

// sizes of the bytecode processor memories

// code memory, one byte per location
`define VM_CODE_AW 8
`define VM_CODE_DEPTH 256

// call stack of return addresses
`define VM_STACK_AW 8
`define VM_STACK_DEPTH 256

// variable registers, indexed by one operand byte
`define VM_VAR_COUNT 256

`endif

//--- src/vm_isa_pkg.sv
`default_nettype none

package vm_isa_pkg;

  // opcode values follow the original bytecode encoding
  typedef enum logic [7:0] {
    op_mov_const   = 8'h00,
    op_mov         = 8'h01,
    op_add         = 8'h02,
    op_add_const   = 8'h03,
    op_call        = 8'h04,
    op_ret         = 8'h05,
    op_jmp         = 8'h07,
    op_djnz        = 8'h09,
    op_cond_jmp    = 8'h0A,
    op_kill_thread = 8'h11,
    op_sub         = 8'h13,
    op_and         = 8'h14,
    op_or          = 8'h15,
    op_shl         = 8'h16,
    op_shr         = 8'h17
  } opcode_e;

  // condJmp compare selector, sub-opcode bits 2..0
  // codes 6 and 7 are never taken
  typedef enum logic [2:0] {
    cond_jz  = 3'd0,
    cond_jnz = 3'd1,
    cond_jg  = 3'd2,
    cond_jge = 3'd3,
    cond_jl  = 3'd4,
    cond_jle = 3'd5
  } cond_e;

  typedef enum logic [3:0] {
    alu_pass,
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_shl,
    alu_shr,
    alu_dec
  } alu_op_e;

endpackage

`default_nettype wire

//--- src/vm_data_pkg.sv
`default_nettype none

`include "vm_params.svh"

package vm_data_pkg;

  // one bytecode byte
  typedef logic [7:0] byte_t;

  // variable value or immediate operand
  typedef logic [15:0] word_t;

  // program address, low bits index the code memory
  typedef logic [15:0] pc_t;

  typedef logic [7:0] var_idx_t;

  typedef logic [`VM_STACK_AW-1:0] sp_t;

endpackage

`default_nettype wire

//--- src/vm_if.sv
`timescale 1ns/10ps
`default_nettype none

// variable register access, two reads and one write
interface vm_var_if;
  import vm_data_pkg::*;

  var_idx_t idx_a;
  var_idx_t idx_b;
  logic     wr_en;
  var_idx_t wr_idx;
  word_t    wr_data;
  word_t    data_a;
  word_t    data_b;

  modport seq (output idx_a, idx_b, wr_en, wr_idx, wr_data, input data_a, data_b);
  modport file (input idx_a, idx_b, wr_en, wr_idx, wr_data, output data_a, data_b);
endinterface

// operands to the ALU, result and branch decision back
interface vm_alu_if;
  import vm_data_pkg::*;
  import vm_isa_pkg::*;

  alu_op_e op;
  word_t   a;
  word_t   b;
  cond_e   cond;
  word_t   result;
  logic    taken;

  modport seq (output op, a, b, cond, input result, taken);
  modport alu (input op, a, b, cond, output result, taken);
endinterface

// return address stack
interface vm_stack_if;
  import vm_data_pkg::*;

  logic push;
  logic pop;
  pc_t  push_pc;
  pc_t  top_pc;

  modport seq (output push, pop, push_pc, input top_pc);
  modport stack (input push, pop, push_pc, output top_pc);
endinterface

`default_nettype wire

//--- src/vm_ram.sv
`timescale 1ns/10ps
`default_nettype none

`include "vm_params.svh"

module vm_ram #(
  parameter type payload_t = vm_data_pkg::byte_t,
  parameter int  depth     = `VM_CODE_DEPTH,
  parameter int  addr_w    = $clog2(depth)
) (
  input  wire logic              clk,
  input  wire logic              we,
  input  wire logic [addr_w-1:0] addr,
  input  payload_t               wdata,
  output payload_t               rdata
);

  payload_t mem [depth];

  // read returns the old contents on a write to the same address
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

endmodule

`default_nettype wire

//--- src/vm_var_file.sv
`timescale 1ns/10ps
`default_nettype none

`include "vm_params.svh"

module vm_var_file (
  input  wire logic                clk,
  input  wire logic                reset,
  vm_var_if.file                   port,
  input  vm_data_pkg::var_idx_t    var_sel,
  output vm_data_pkg::word_t       var_value
);
  import vm_data_pkg::*;

  word_t vars_q [`VM_VAR_COUNT];

  always_ff @(posedge clk) begin
    if (!reset) begin
      for (int i = 0; i < `VM_VAR_COUNT; i++) begin
        vars_q[i] <= '0;
      end
    end else if (port.wr_en) begin
      vars_q[port.wr_idx] <= port.wr_data;
    end
  end

  // sequencer operand reads
  assign port.data_a = vars_q[port.idx_a];
  assign port.data_b = vars_q[port.idx_b];

  // host view, no latency
  assign var_value = vars_q[var_sel];

endmodule

`default_nettype wire

//--- src/vm_alu.sv
`timescale 1ns/10ps
`default_nettype none

module vm_alu (
  vm_alu_if.alu port
);
  import vm_isa_pkg::*;

  // shift count beyond the word width clears the result
  logic shift_out;

  assign shift_out = |port.b[15:4];

  always_comb begin
    case (port.op)
      alu_pass: port.result = port.b;
      alu_add:  port.result = port.a + port.b;
      alu_sub:  port.result = port.a - port.b;
      alu_and:  port.result = port.a & port.b;
      alu_or:   port.result = port.a | port.b;
      alu_shl: begin
        if (shift_out) port.result = '0;
        else port.result = port.a << port.b[3:0];
      end
      alu_shr: begin
        if (shift_out) port.result = '0;
        else port.result = port.a >> port.b[3:0];
      end
      alu_dec:  port.result = port.a - 16'd1;
      default:  port.result = port.b;
    endcase
  end

  // unsigned compare of a against b for condJmp
  always_comb begin
    case (port.cond)
      cond_jz:  port.taken = (port.a == port.b);
      cond_jnz: port.taken = (port.a != port.b);
      cond_jg:  port.taken = (port.a > port.b);
      cond_jge: port.taken = (port.a >= port.b);
      cond_jl:  port.taken = (port.a < port.b);
      cond_jle: port.taken = (port.a <= port.b);
      default:  port.taken = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- src/vm_call_stack.sv
`timescale 1ns/10ps
`default_nettype none

`include "vm_params.svh"

module vm_call_stack (
  input wire logic clk,
  input wire logic reset,
  vm_stack_if.stack port
);
  import vm_data_pkg::*;

  sp_t sp;
  sp_t ram_addr;

  // push writes at sp, pop reads the slot below it
  assign ram_addr = port.pop ? sp - sp_t'(1) : sp;

  // pointer wraps, no overflow guard
  always_ff @(posedge clk) begin
    if (!reset) begin
      sp <= '0;
    end else if (port.push) begin
      sp <= sp + sp_t'(1);
    end else if (port.pop) begin
      sp <= sp - sp_t'(1);
    end
  end

  vm_ram #(
    .payload_t (pc_t),
    .depth     (`VM_STACK_DEPTH),
    .addr_w    (`VM_STACK_AW)
  ) stack_ram_inst (
    .clk   (clk),
    .we    (port.push),
    .addr  (ram_addr),
    .wdata (port.push_pc),
    .rdata (port.top_pc)
  );

endmodule

`default_nettype wire

//--- src/vm_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module vm_sequencer (
  input  wire logic          clk,
  input  wire logic          reset,
  output vm_data_pkg::pc_t   code_addr,
  input  vm_data_pkg::byte_t code_data,
  output logic               halted,
  vm_var_if.seq              vars,
  vm_alu_if.seq              alu,
  vm_stack_if.seq            stk
);
  import vm_data_pkg::*;
  import vm_isa_pkg::*;

  typedef enum logic [2:0] {
    s_fill,
    s_opcode,
    s_operand,
    s_exec,
    s_ret,
    s_halt
  } state_e;

  state_e   state;
  pc_t      pc;
  logic [2:0] step;
  logic [2:0] n_last;
  logic [2:0] rem;
  opcode_e  opcode;
  var_idx_t dst;
  var_idx_t src;
  byte_t    sub;
  word_t    imm;
  pc_t      target;

  logic two_reg;
  logic has_dst;
  logic has_target;
  logic is_write;
  logic use_var_b;

  ////////////////////////////////////////////////////////////
  // decode of the held opcode

  assign two_reg    = opcode inside {op_mov, op_add, op_sub, op_and, op_or};
  assign has_dst    = !(opcode inside {op_jmp, op_call, op_cond_jmp});
  assign has_target = opcode inside {op_jmp, op_call, op_djnz, op_cond_jmp};
  assign is_write   = two_reg || (opcode inside {op_mov_const, op_add_const, op_shl,
                                                 op_shr, op_djnz});
  assign use_var_b  = two_reg || (opcode == op_cond_jmp && sub[7]);

  // bytes still to come, counts the trailing value fields from their low byte
  assign rem = n_last - step;

  // memory address is the PC, the byte comes back next cycle
  assign code_addr = pc;
  assign halted    = (state == s_halt);

  ////////////////////////////////////////////////////////////
  // operand routing

  assign vars.idx_a   = (opcode == op_cond_jmp) ? src : dst;
  assign vars.idx_b   = (opcode == op_cond_jmp) ? imm[7:0] : src;
  assign vars.wr_en   = (state == s_exec) && is_write;
  assign vars.wr_idx  = dst;
  assign vars.wr_data = alu.result;

  assign alu.a    = vars.data_a;
  assign alu.b    = use_var_b ? vars.data_b : imm;
  assign alu.cond = cond_e'(sub[2:0]);

  always_comb begin
    case (opcode)
      op_add, op_add_const: alu.op = alu_add;
      op_sub:               alu.op = alu_sub;
      op_and:               alu.op = alu_and;
      op_or:                alu.op = alu_or;
      op_shl:               alu.op = alu_shl;
      op_shr:               alu.op = alu_shr;
      op_djnz:              alu.op = alu_dec;
      default:              alu.op = alu_pass;
    endcase
  end

  // pc already points past the call when it executes
  assign stk.push    = (state == s_exec) && (opcode == op_call);
  assign stk.pop     = (state == s_exec) && (opcode == op_ret);
  assign stk.push_pc = pc;

  ////////////////////////////////////////////////////////////
  // fetch and step control

  always_ff @(posedge clk) begin
    if (!reset) begin
      state <= s_fill;
      pc    <= '0;
      step  <= '0;
    end else begin
      case (state)
        s_fill: begin
          pc    <= pc + pc_t'(1);
          state <= s_opcode;
        end
        s_opcode: begin
          opcode <= opcode_e'(code_data);
          imm    <= '0;
          step   <= '0;
          pc     <= pc + pc_t'(1);
          state  <= s_operand;
          case (code_data)
            op_mov_const, op_shl, op_shr, op_djnz: n_last <= 3'd2;
            op_mov, op_add, op_sub, op_and, op_or: n_last <= 3'd1;
            op_add_const, op_jmp, op_call:         n_last <= 3'd1;
            op_cond_jmp:                           n_last <= 3'd4;
            op_ret: begin
              pc    <= pc;
              state <= s_exec;
            end
            // killThread and anything unknown
            default: begin
              pc    <= pc;
              state <= s_halt;
            end
          endcase
        end
        s_operand: begin
          if (opcode == op_cond_jmp && step == 3'd0) begin
            sub <= code_data;
            // imm16 compare operand is one byte longer
            if (code_data[6] && !code_data[7]) begin
              n_last <= 3'd5;
            end
          end else if (step == 3'd1 && (two_reg || opcode == op_cond_jmp)) begin
            src <= code_data;
          end else if (step == 3'd0 && has_dst) begin
            dst <= code_data;
          end else if (has_target && rem < 3'd2) begin
            if (rem[0]) target[15:8] <= code_data;
            else target[7:0] <= code_data;
          end else begin
            if (rem[0]) imm[15:8] <= code_data;
            else imm[7:0] <= code_data;
          end
          if (step == n_last) begin
            state <= s_exec;
          end else begin
            step <= step + 3'd1;
            pc   <= pc + pc_t'(1);
          end
        end
        s_exec: begin
          // overlap the next opcode fetch unless the flow changes
          pc    <= pc + pc_t'(1);
          state <= s_opcode;
          case (opcode)
            op_jmp, op_call: begin
              pc    <= target;
              state <= s_fill;
            end
            op_djnz: begin
              if (alu.result != '0) begin
                pc    <= target;
                state <= s_fill;
              end
            end
            op_cond_jmp: begin
              if (alu.taken) begin
                pc    <= target;
                state <= s_fill;
              end
            end
            op_ret: begin
              pc    <= pc;
              state <= s_ret;
            end
            default: ;
          endcase
        end
        s_ret: begin
          pc    <= stk.top_pc;
          state <= s_fill;
        end
        s_halt: state <= s_halt;
        default: state <= s_halt;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/vm_core_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "vm_params.svh"

module vm_core_top (
  input  wire logic              clk,
  input  wire logic              reset,
  input  wire logic              prog_we,
  input  vm_data_pkg::pc_t       prog_addr,
  input  vm_data_pkg::byte_t     prog_data,
  input  vm_data_pkg::var_idx_t  var_sel,
  output vm_data_pkg::word_t     var_value,
  output logic                   halted
);
  import vm_data_pkg::*;

  pc_t   code_addr;
  byte_t code_data;
  logic  code_we;
  logic [`VM_CODE_AW-1:0] code_ram_addr;

  vm_var_if   var_bus ();
  vm_alu_if   alu_bus ();
  vm_stack_if stack_bus ();

  ////////////////////////////////////////////////////////////
  // code memory, host owns the port while reset is held

  assign code_we       = prog_we && !reset;
  assign code_ram_addr = reset ? code_addr[`VM_CODE_AW-1:0] : prog_addr[`VM_CODE_AW-1:0];

  vm_ram #(
    .payload_t (byte_t),
    .depth     (`VM_CODE_DEPTH),
    .addr_w    (`VM_CODE_AW)
  ) code_ram_inst (
    .clk   (clk),
    .we    (code_we),
    .addr  (code_ram_addr),
    .wdata (prog_data),
    .rdata (code_data)
  );

  ////////////////////////////////////////////////////////////
  // processor

  vm_sequencer vm_sequencer_inst (
    .clk       (clk),
    .reset     (reset),
    .code_addr (code_addr),
    .code_data (code_data),
    .halted    (halted),
    .vars      (var_bus.seq),
    .alu       (alu_bus.seq),
    .stk       (stack_bus.seq)
  );

  vm_var_file vm_var_file_inst (
    .clk       (clk),
    .reset     (reset),
    .port      (var_bus.file),
    .var_sel   (var_sel),
    .var_value (var_value)
  );

  vm_alu vm_alu_inst (
    .port (alu_bus.alu)
  );

  vm_call_stack vm_call_stack_inst (
    .clk   (clk),
    .reset (reset),
    .port  (stack_bus.stack)
  );

endmodule

`default_nettype wire

//--- dv/vm_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module vm_assertions (
  input wire logic clk,
  input wire logic reset,
  input wire logic halted,
  input wire logic push,
  input wire logic pop,
  input wire logic wr_en
);

  // once halted, only a reset brings the core back
  halted_holds: assert property (
    @(posedge clk) disable iff (!reset) $past(halted) |-> halted
  ) else $error("halted fell while reset was released");

  // the stack sees one operation per cycle
  push_pop_exclusive: assert property (
    @(posedge clk) disable iff (!reset) !(push && pop)
  ) else $error("call stack push and pop active in the same cycle");

  // a halted core leaves the variables alone
  no_write_halted: assert property (
    @(posedge clk) disable iff (!reset) halted |-> !wr_en
  ) else $error("variable write while halted");

endmodule

bind vm_sequencer vm_assertions vm_assertions_inst (
  .clk    (clk),
  .reset  (reset),
  .halted (halted),
  .push   (stk.push),
  .pop    (stk.pop),
  .wr_en  (vars.wr_en)
);

`default_nettype wire

//--- dv/vm_tb.sv
`timescale 1ns/10ps
`default_nettype none

module vm_tb;
  import vm_data_pkg::*;
  import vm_isa_pkg::*;

  localparam int timeout_cycles = 20000;

  logic     clk;
  logic     reset;
  logic     prog_we;
  pc_t      prog_addr;
  byte_t    prog_data;
  var_idx_t var_sel;
  word_t    var_value;
  logic     halted;

  // program image and the expected final variables
  byte_t       prog [256];
  int unsigned emit_pc;
  word_t       exp_vars [256];
  logic [31:0] lcg_state;
  logic        cmp_req;
  string       test_name;

  vm_core_top vm_core_top_inst (
    .clk       (clk),
    .reset     (reset),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .var_sel   (var_sel),
    .var_value (var_value),
    .halted    (halted)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // random constants and program building

  function automatic word_t rand_word();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];
  endfunction

  function automatic void clear_prog();
    for (int i = 0; i < 256; i++) begin
      prog[i] = byte_t'(op_kill_thread);
    end
    emit_pc = 0;
  endfunction

  function automatic void emit(input byte_t b);
    prog[emit_pc[7:0]] = b;
    emit_pc = emit_pc + 1;
  endfunction

  function automatic void emit_word(input word_t w);
    emit(w[15:8]);
    emit(w[7:0]);
  endfunction

  function automatic void emit_mov_const(input var_idx_t dst, input word_t imm);
    emit(byte_t'(op_mov_const));
    emit(dst);
    emit_word(imm);
  endfunction

  // register pairs and addConst take two operand bytes
  function automatic void emit_pair(input opcode_e op, input var_idx_t dst, input byte_t src);
    emit(byte_t'(op));
    emit(dst);
    emit(src);
  endfunction

  function automatic void emit_target(input opcode_e op, input word_t target);
    emit(byte_t'(op));
    emit_word(target);
  endfunction

  ////////////////////////////////////////////////////////////
  // reference interpreter

  function automatic byte_t next_byte(inout pc_t pc);
    byte_t b;
    b = prog[pc[7:0]];
    pc = pc + 16'd1;
    return b;
  endfunction

  function automatic word_t next_word(inout pc_t pc);
    byte_t hi;
    byte_t lo;
    hi = next_byte(pc);
    lo = next_byte(pc);
    return {hi, lo};
  endfunction

  function automatic bit cond_true(input logic [2:0] code, input word_t a, input word_t b);
    case (code)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd2: return a > b;
      3'd3: return a >= b;
      3'd4: return a < b;
      3'd5: return a <= b;
      default: return 1'b0;
    endcase
  endfunction

  // runs prog and leaves the final variables in exp_vars
  function automatic void ref_run();
    pc_t   pc;
    pc_t   ret_stack [256];
    byte_t sp;
    byte_t op;
    byte_t sub;
    byte_t dst;
    byte_t src;
    word_t opnd;
    word_t target;
    bit    running;
    int    steps;
    for (int i = 0; i < 256; i++) begin
      exp_vars[i] = '0;
    end
    pc = '0;
    sp = '0;
    running = 1'b1;
    steps = 0;
    while (running && steps < timeout_cycles) begin
      steps++;
      op = next_byte(pc);
      case (op)
        op_mov_const: begin
          dst = next_byte(pc);
          exp_vars[dst] = next_word(pc);
        end
        op_mov, op_add, op_sub, op_and, op_or: begin
          dst = next_byte(pc);
          src = next_byte(pc);
          case (op)
            op_mov: exp_vars[dst] = exp_vars[src];
            op_add: exp_vars[dst] = exp_vars[dst] + exp_vars[src];
            op_sub: exp_vars[dst] = exp_vars[dst] - exp_vars[src];
            op_and: exp_vars[dst] = exp_vars[dst] & exp_vars[src];
            default: exp_vars[dst] = exp_vars[dst] | exp_vars[src];
          endcase
        end
        op_add_const: begin
          dst = next_byte(pc);
          exp_vars[dst] = exp_vars[dst] + {8'h00, next_byte(pc)};
        end
        op_shl, op_shr: begin
          dst = next_byte(pc);
          opnd = next_word(pc);
          if (opnd >= 16'd16) exp_vars[dst] = '0;
          else if (op == op_shl) exp_vars[dst] = exp_vars[dst] << opnd;
          else exp_vars[dst] = exp_vars[dst] >> opnd;
        end
        op_jmp: pc = next_word(pc);
        op_djnz: begin
          dst = next_byte(pc);
          target = next_word(pc);
          exp_vars[dst] = exp_vars[dst] - 16'd1;
          if (exp_vars[dst] != '0) pc = target;
        end
        op_cond_jmp: begin
          sub = next_byte(pc);
          src = next_byte(pc);
          if (sub[7]) opnd = exp_vars[next_byte(pc)];
          else if (sub[6]) opnd = next_word(pc);
          else opnd = {8'h00, next_byte(pc)};
          target = next_word(pc);
          if (cond_true(sub[2:0], exp_vars[src], opnd)) pc = target;
        end
        op_call: begin
          target = next_word(pc);
          ret_stack[sp] = pc;
          sp = sp + 8'd1;
          pc = target;
        end
        op_ret: begin
          sp = sp - 8'd1;
          pc = ret_stack[sp];
        end
        default: running = 1'b0;
      endcase
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // checks

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_var(input string name, input var_idx_t idx, input word_t exp,
                           input word_t act);
    if (act !== exp) begin
      report_failure($sformatf("[ERROR] %s: var %0d expected %h actual %h",
                               name, idx, exp, act));
    end
  endtask

  task automatic check_halted(input string name, input bit exp, input bit act);
    if (act !== exp) begin
      report_failure($sformatf("[ERROR] %s: halted expected %0b actual %0b",
                               name, exp, act));
    end
  endtask

  task automatic read_var(input var_idx_t idx, output word_t value);
    @(posedge clk);
    #1;
    var_sel = idx;
    #20;
    value = var_value;
  endtask

  // compares every variable with the reference once requested
  initial begin : compare_proc
    forever begin
      @(posedge clk);
      if (cmp_req) begin
        for (int i = 0; i < 256; i++) begin
          @(posedge clk);
          #1;
          var_sel = var_idx_t'(i);
          #20;
          check_var(test_name, var_idx_t'(i), exp_vars[i], var_value);
        end
        cmp_req = 1'b0;
      end
    end
  end

  // load under reset, run to halted, then compare all variables
  task automatic run_program(input string name);
    int cycles;
    test_name = name;
    ref_run();
    @(posedge clk);
    #1;
    reset = 1'b0;
    for (int i = 0; i < 256; i++) begin
      prog_we   = 1'b1;
      prog_addr = pc_t'(i);
      prog_data = prog[i];
      @(posedge clk);
      #1;
    end
    prog_we = 1'b0;
    repeat (5) begin
      @(posedge clk);
      #1;
      check_halted(name, 1'b0, halted);
    end
    reset = 1'b1;
    @(posedge clk);
    #1;
    check_halted(name, 1'b0, halted);
    cycles = 0;
    while (!halted && cycles < timeout_cycles) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!halted) begin
      report_failure($sformatf("%s: halted did not rise within %0d cycles",
                               name, timeout_cycles));
    end
    check_halted(name, 1'b1, halted);
    cmp_req = 1'b1;
    cycles = 0;
    while (cmp_req && cycles < timeout_cycles) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (cmp_req) begin
      report_failure($sformatf("%s: variable compare did not finish", name));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // tests

  initial begin : main_proc
    word_t       a;
    word_t       b;
    word_t       value;
    byte_t       sub;
    int unsigned cj_size;
    int unsigned t_addr;
    reset     = 1'b0;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    var_sel   = '0;
    cmp_req   = 1'b0;
    lcg_state = 32'h8a69_4942;

    // a lone halt byte
    clear_prog();
    run_program("halt_only");

    // straight-line arithmetic
    clear_prog();
    for (int i = 1; i <= 6; i++) begin
      emit_mov_const(var_idx_t'(i), rand_word());
    end
    emit_pair(op_mov, 8'd7, 8'd1);
    emit_pair(op_add, 8'd7, 8'd2);
    emit_pair(op_mov, 8'd8, 8'd3);
    emit_pair(op_sub, 8'd8, 8'd4);
    emit_pair(op_mov, 8'd9, 8'd5);
    emit_pair(op_and, 8'd9, 8'd6);
    emit_pair(op_mov, 8'd10, 8'd1);
    emit_pair(op_or, 8'd10, 8'd4);
    emit_pair(op_add_const, 8'd2, byte_t'(rand_word()));
    emit(byte_t'(op_shl));
    emit(8'd3);
    emit_word(rand_word() & 16'h000f);
    emit(byte_t'(op_shr));
    emit(8'd4);
    emit_word(rand_word() & 16'h000f);
    emit(byte_t'(op_shl));
    emit(8'd5);
    emit_word(16'd20);
    run_program("straight_line");

    // djnz accumulation loop
    clear_prog();
    emit_mov_const(8'd1, (rand_word() % 16'd20) + 16'd1);
    emit_mov_const(8'd2, 16'h0000);
    emit_mov_const(8'd3, rand_word());
    t_addr = emit_pc;
    emit_pair(op_add, 8'd2, 8'd3);
    emit(byte_t'(op_djnz));
    emit(8'd1);
    emit_word(word_t'(t_addr));
    run_program("djnz_loop");
    read_var(8'd1, value);
    check_var("djnz_loop", 8'd1, 16'h0000, value);

    // condJmp operand form 0 is a variable, 1 is imm16 and 2 is imm8
    for (int f = 0; f < 3; f++) begin
      clear_prog();
      for (int k = 0; k < 8; k++) begin
        a = rand_word() & 16'h0101;
        b = rand_word() & 16'h0101;
        emit_mov_const(8'd1, a);
        if (f == 0) emit_mov_const(8'd2, b);
        sub = {(f == 0), (f == 1), 3'b000, 3'(k)};
        cj_size = (f == 1) ? 7 : 6;
        t_addr = emit_pc + cj_size + 3;
        emit(byte_t'(op_cond_jmp));
        emit(sub);
        emit(8'd1);
        if (f == 0) emit(8'd2);
        else if (f == 1) emit_word(b);
        else emit(b[7:0]);
        emit_word(word_t'(t_addr));
        emit_target(op_jmp, word_t'(t_addr + 4));
        emit_mov_const(var_idx_t'(16 + k), 16'h0001);
      end
      run_program($sformatf("cond_jmp_form%0d", f));
      read_var(8'd22, value);
      check_var("cond_jmp_code6", 8'd22, 16'h0000, value);
      read_var(8'd23, value);
      check_var("cond_jmp_code7", 8'd23, 16'h0000, value);
    end

    // nested call and ret with v0 counting the visits
    clear_prog();
    emit_target(op_call, 16'h0020);
    emit_pair(op_add_const, 8'd0, 8'd1);
    emit_pair(op_mov, 8'd10, 8'd0);
    emit_pc = 32'h20;
    emit_pair(op_add_const, 8'd0, 8'd1);
    emit_pair(op_mov, 8'd11, 8'd0);
    emit_target(op_call, 16'h0040);
    emit_pair(op_add_const, 8'd0, 8'd1);
    emit_pair(op_mov, 8'd12, 8'd0);
    emit(byte_t'(op_ret));
    emit_pc = 32'h40;
    emit_pair(op_add_const, 8'd0, 8'd1);
    emit_pair(op_mov, 8'd13, 8'd0);
    emit_target(op_jmp, 16'h004d);
    emit_mov_const(8'd20, 16'hffff);
    emit(byte_t'(op_ret));
    run_program("call_ret");
    read_var(8'd11, value);
    check_var("call_ret_order", 8'd11, 16'd1, value);
    read_var(8'd13, value);
    check_var("call_ret_order", 8'd13, 16'd2, value);
    read_var(8'd12, value);
    check_var("call_ret_order", 8'd12, 16'd3, value);
    read_var(8'd10, value);
    check_var("call_ret_order", 8'd10, 16'd4, value);

    // unknown opcode stops the program
    clear_prog();
    emit_mov_const(8'd1, rand_word());
    emit_mov_const(8'd2, rand_word());
    emit_pair(op_add, 8'd1, 8'd2);
    emit(8'h0e);
    emit_mov_const(8'd3, 16'h1234);
    emit_pair(op_add, 8'd1, 8'd2);
    run_program("unknown_opcode");
    read_var(8'd3, value);
    check_var("unknown_opcode", 8'd3, 16'h0000, value);

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+src
src/vm_isa_pkg.sv
src/vm_data_pkg.sv
src/vm_if.sv
src/vm_ram.sv
src/vm_var_file.sv
src/vm_alu.sv
src/vm_call_stack.sv
src/vm_sequencer.sv
src/vm_core_top.sv
dv/vm_assertions.sv
dv/vm_tb.sv

//--- run.sh
#!/bin/sh
# compile with Verilator and run; success only when the pass line appears
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module vm_tb -o vm_sim \
  && ./obj_dir/vm_sim | tee /dev/stderr | grep -q "Result: PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
